//--- logic/model_buffer_settings.svh
`ifndef MODEL_BUFFER_SETTINGS_SVH
`define MODEL_BUFFER_SETTINGS_SVH

// Registry slots, one per model number
`define MB_MODEL_COUNT 8

// Shared memory depth in triangles
`define MB_TRIANGLE_COUNT 256

// Bits per coordinate
`define MB_COORD_WIDTH 16

`endif

//--- logic/model_buffer_pkg.sv
`default_nettype none

`include "model_buffer_settings.svh"

package model_buffer_pkg;

    typedef logic [$clog2(`MB_MODEL_COUNT)-1:0] model_idx_t;

    // Address into the shared memory, also used for an index inside a model
    typedef logic [$clog2(`MB_TRIANGLE_COUNT)-1:0] tri_idx_t;

    // One bit wider so a completely full memory can be counted
    typedef logic [$clog2(`MB_TRIANGLE_COUNT):0] tri_count_t;

    typedef struct packed {
        logic [`MB_COORD_WIDTH-1:0] x;
        logic [`MB_COORD_WIDTH-1:0] y;
        logic [`MB_COORD_WIDTH-1:0] z;
    } vertex_t;

    // Element 0 is the leftmost, so vertex 0 lands in the high bits
    typedef vertex_t [0:2] triangle_t;

    typedef enum logic [1:0] {
        MODEL_EMPTY   = 2'b00,
        MODEL_WRITING = 2'b01,
        MODEL_WRITTEN = 2'b10
    } model_state_e;

    typedef struct packed {
        tri_idx_t     start;   // First address of the model
        tri_count_t   size;    // Triangles stored so far
        model_state_e state;
    } registry_entry_t;

endpackage

`default_nettype wire

//--- logic/model_buffer_ifs.sv
`default_nettype none

// Registry to one vertex bank; write port, read port and read data
interface bank_if;

    logic                       we;
    model_buffer_pkg::tri_idx_t waddr;
    model_buffer_pkg::vertex_t  wdata;
    logic                       re;
    model_buffer_pkg::tri_idx_t raddr;
    model_buffer_pkg::vertex_t  rdata;   // Registered, holds while re is low

    modport feeder (
        output we, waddr, wdata,
        output re, raddr
    );

    modport bank (
        input  we, waddr, wdata,
        input  re, raddr,
        output rdata
    );

endinterface

// Registry to output stage, describes the request accepted this cycle
interface lookup_if;

    logic                         accept;
    logic                         hit;     // Index below model size
    logic                         last;    // Index is the final one of the model
    model_buffer_pkg::model_idx_t model;
    model_buffer_pkg::tri_idx_t   index;
    logic                         can_take;

    modport source (
        output accept, hit, last, model, index,
        input  can_take
    );

    modport sink (
        input  accept, hit, last, model, index,
        output can_take
    );

endinterface

`default_nettype wire

//--- logic/vertex_bank.sv
`default_nettype none

`include "model_buffer_settings.svh"

module vertex_bank (
    input wire logic clk,
    bank_if.bank     mem
);

    // One vertex of every stored triangle, mapped to block RAM
    model_buffer_pkg::vertex_t ram [`MB_TRIANGLE_COUNT];

    model_buffer_pkg::vertex_t rdata_q;

    always_ff @(posedge clk) begin
        if (mem.we) begin
            ram[mem.waddr] <= mem.wdata;
        end
    end

    // Read register only moves on re so a stalled result stays put
    always_ff @(posedge clk) begin
        if (mem.re) begin
            rdata_q <= ram[mem.raddr];
        end
    end

    assign mem.rdata = rdata_q;

    // No write forwarding, so a read must never hit the address being written
    no_rw_collision: assert property (@(posedge clk)
        !(mem.re && mem.we && (mem.raddr == mem.waddr)));

endmodule

`default_nettype wire

//--- logic/model_registry.sv
`default_nettype none

`include "model_buffer_settings.svh"

module model_registry (
    input  wire logic                        clk,
    input  wire logic                        rstn,

    input  wire logic                        write_valid,
    input  wire model_buffer_pkg::model_idx_t write_model,
    input  wire model_buffer_pkg::triangle_t  write_triangle,

    input  wire logic                        read_valid,
    input  wire model_buffer_pkg::model_idx_t read_model,
    input  wire model_buffer_pkg::tri_idx_t   read_index,

    bank_if.feeder                           bank0,
    bank_if.feeder                           bank1,
    bank_if.feeder                           bank2,

    lookup_if.source                         lookup
);

    model_buffer_pkg::registry_entry_t reg_table_q [`MB_MODEL_COUNT];

    model_buffer_pkg::tri_count_t next_free_q;   // Memory is filled from address 0 upward
    model_buffer_pkg::model_idx_t prev_model_q;
    logic                         prev_seen_q;   // No model written yet after reset
    model_buffer_pkg::tri_count_t run_idx_q;     // Triangles written to prev_model_q

    model_buffer_pkg::registry_entry_t wr_entry;
    model_buffer_pkg::registry_entry_t rd_entry;
    logic                              wr_claim;
    logic                              wr_append;
    logic                              mem_full;
    logic                              wr_accept;
    logic                              model_change;
    model_buffer_pkg::tri_count_t      wr_offset;
    model_buffer_pkg::tri_count_t      wr_addr_full;
    model_buffer_pkg::tri_idx_t        rd_addr;

    // Write decode
    always_comb begin
        wr_entry  = reg_table_q[write_model];
        wr_claim  = wr_entry.state == model_buffer_pkg::MODEL_EMPTY;
        wr_append = wr_entry.state == model_buffer_pkg::MODEL_WRITING;
        mem_full  = next_free_q == model_buffer_pkg::tri_count_t'(`MB_TRIANGLE_COUNT);
        // Sealed models and a full memory swallow the write
        wr_accept = write_valid && (wr_claim || wr_append) && !mem_full;
        wr_offset = wr_claim ? '0 : run_idx_q;
        if (wr_claim) begin
            wr_addr_full = next_free_q;
        end else begin
            wr_addr_full = model_buffer_pkg::tri_count_t'(wr_entry.start) + run_idx_q;
        end
        model_change = prev_seen_q && (write_model != prev_model_q);
    end

    // Read decode
    always_comb begin
        rd_entry = reg_table_q[read_model];
        rd_addr  = rd_entry.start + read_index;   // Wraps like the memory does
    end

    assign lookup.accept = read_valid && lookup.can_take;
    assign lookup.hit    = {1'b0, read_index} < rd_entry.size;
    assign lookup.last   = ({1'b0, read_index} + 1'b1) == rd_entry.size;
    assign lookup.model  = read_model;
    assign lookup.index  = read_index;

    // Same address and strobes on all banks, each takes its own vertex
    always_comb begin
        bank0.we    = wr_accept;
        bank0.waddr = model_buffer_pkg::tri_idx_t'(wr_addr_full);
        bank0.wdata = write_triangle[0];
        bank0.re    = lookup.accept && lookup.hit;   // Misses leave the banks idle
        bank0.raddr = rd_addr;

        bank1.we    = wr_accept;
        bank1.waddr = model_buffer_pkg::tri_idx_t'(wr_addr_full);
        bank1.wdata = write_triangle[1];
        bank1.re    = lookup.accept && lookup.hit;
        bank1.raddr = rd_addr;

        bank2.we    = wr_accept;
        bank2.waddr = model_buffer_pkg::tri_idx_t'(wr_addr_full);
        bank2.wdata = write_triangle[2];
        bank2.re    = lookup.accept && lookup.hit;
        bank2.raddr = rd_addr;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < `MB_MODEL_COUNT; i++) begin
                reg_table_q[i] <= '{start: '0, size: '0, state: model_buffer_pkg::MODEL_EMPTY};
            end
            next_free_q  <= '0;
            prev_model_q <= '0;
            prev_seen_q  <= 1'b0;
            run_idx_q    <= '0;
        end else if (wr_accept) begin
            // Moving on to another model closes the previous one for good.
            // Dropped writes do not count as a move.
            if (model_change &&
                reg_table_q[prev_model_q].state == model_buffer_pkg::MODEL_WRITING) begin
                reg_table_q[prev_model_q].state <= model_buffer_pkg::MODEL_WRITTEN;
            end
            if (wr_claim) begin
                reg_table_q[write_model].start <= model_buffer_pkg::tri_idx_t'(next_free_q);
                reg_table_q[write_model].state <= model_buffer_pkg::MODEL_WRITING;
            end
            reg_table_q[write_model].size <= wr_offset + 1'b1;
            run_idx_q    <= wr_offset + 1'b1;
            next_free_q  <= next_free_q + 1'b1;
            prev_model_q <= write_model;
            prev_seen_q  <= 1'b1;
        end
    end

    // Appends must follow the model start and stay inside the memory
    wr_in_range: assert property (@(posedge clk) disable iff (!rstn)
        bank0.we |-> wr_addr_full < model_buffer_pkg::tri_count_t'(`MB_TRIANGLE_COUNT));

endmodule

`default_nettype wire

//--- logic/triangle_output.sv
`default_nettype none

module triangle_output (
    input  wire logic                    clk,
    input  wire logic                    rstn,

    lookup_if.sink                       lookup,

    // Only rdata is used from the banks
    bank_if.bank                         bank0,
    bank_if.bank                         bank1,
    bank_if.bank                         bank2,

    output logic                         read_ready,
    output logic                         out_valid,
    input  wire logic                    out_ready,
    output model_buffer_pkg::triangle_t  out_triangle,
    output logic                         out_last,
    output model_buffer_pkg::model_idx_t out_model,
    output model_buffer_pkg::tri_idx_t   out_index
);

    logic take;   // Output register is free or drains this cycle

    assign take            = !out_valid || out_ready;
    assign lookup.can_take = take;
    assign read_ready      = take;

    // Vertex 0 in the high bits
    assign out_triangle = {bank0.rdata, bank1.rdata, bank2.rdata};

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else if (lookup.accept) begin
            out_valid <= lookup.hit;    // Out of range requests leave nothing behind
            out_last  <= lookup.last;
        end else if (out_valid && out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // Metadata rides along with the bank read
    always_ff @(posedge clk) begin
        if (lookup.accept) begin
            out_model <= lookup.model;
            out_index <= lookup.index;
        end
    end

    // Registry hands over a request only while the register can take it
    accept_gated: assert property (@(posedge clk) disable iff (!rstn)
        lookup.accept |-> take);

    // Stalled result is frozen, bank data included
    stall_hold: assert property (@(posedge clk) disable iff (!rstn)
        out_valid && !out_ready |=> out_valid && $stable(out_triangle) &&
            $stable(out_last) && $stable(out_model) && $stable(out_index));

endmodule

`default_nettype wire

//--- logic/model_buffer_top.sv
`default_nettype none

module model_buffer_top (
    input  wire logic                         clk,
    input  wire logic                         rstn,

    // Loader side, always accepted
    input  wire logic                         write_valid,
    input  wire model_buffer_pkg::model_idx_t write_model,
    input  wire model_buffer_pkg::triangle_t  write_triangle,

    // Read request
    input  wire logic                         read_valid,
    output logic                              read_ready,
    input  wire model_buffer_pkg::model_idx_t read_model,
    input  wire model_buffer_pkg::tri_idx_t   read_index,

    // Read result
    output logic                              out_valid,
    input  wire logic                         out_ready,
    output model_buffer_pkg::triangle_t       out_triangle,
    output logic                              out_last,
    output model_buffer_pkg::model_idx_t      out_model,
    output model_buffer_pkg::tri_idx_t        out_index
);

    bank_if   bank_link [3] ();   // One per vertex
    lookup_if lookup_link ();

    model_registry u_registry (
        .clk            (clk),
        .rstn           (rstn),
        .write_valid    (write_valid),
        .write_model    (write_model),
        .write_triangle (write_triangle),
        .read_valid     (read_valid),
        .read_model     (read_model),
        .read_index     (read_index),
        .bank0          (bank_link[0]),
        .bank1          (bank_link[1]),
        .bank2          (bank_link[2]),
        .lookup         (lookup_link)
    );

    for (genvar g = 0; g < 3; g++) begin : g_bank
        vertex_bank u_bank (
            .clk (clk),
            .mem (bank_link[g])
        );
    end

    triangle_output u_output (
        .clk          (clk),
        .rstn         (rstn),
        .lookup       (lookup_link),
        .bank0        (bank_link[0]),
        .bank1        (bank_link[1]),
        .bank2        (bank_link[2]),
        .read_ready   (read_ready),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_triangle (out_triangle),
        .out_last     (out_last),
        .out_model    (out_model),
        .out_index    (out_index)
    );

endmodule

`default_nettype wire

//--- tb/tb_model_buffer.sv
`default_nettype none

`include "model_buffer_settings.svh"

module tb_model_buffer;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_LEN        = 32;   // Longest random model
    localparam int MODELS_USED    = 5;
    localparam int REVISIT_WRITES = 4;
    localparam int FILL_EXTRA     = 6;    // Writes beyond the capacity left
    localparam int CHECK_WIDTH    = 3 * 3 * `MB_COORD_WIDTH;
    localparam int SCHEDULED_OPS  = `MB_MODEL_COUNT             // Reads after reset
                                  + 2 * MODELS_USED * MAX_LEN   // Fill and read back
                                  + 3 * MODELS_USED             // Out of range reads
                                  + REVISIT_WRITES + MAX_LEN + 1
                                  + MODELS_USED * MAX_LEN       // Read back under stalls
                                  + `MB_TRIANGLE_COUNT + FILL_EXTRA + 2
                                  + `MB_TRIANGLE_COUNT + 2;
    localparam int CYCLE_LIMIT    = 4 * SCHEDULED_OPS + 200;

    typedef struct packed {
        logic                         hit;
        logic                         last;
        model_buffer_pkg::model_idx_t model;
        model_buffer_pkg::tri_idx_t   index;
        model_buffer_pkg::triangle_t  triangle;
    } expect_t;

    logic                         clk;
    logic                         rstn;
    logic                         write_valid;
    model_buffer_pkg::model_idx_t write_model;
    model_buffer_pkg::triangle_t  write_triangle;
    logic                         read_valid;
    logic                         read_ready;
    model_buffer_pkg::model_idx_t read_model;
    model_buffer_pkg::tri_idx_t   read_index;
    logic                         out_valid;
    logic                         out_ready;
    model_buffer_pkg::triangle_t  out_triangle;
    logic                         out_last;
    model_buffer_pkg::model_idx_t out_model;
    model_buffer_pkg::tri_idx_t   out_index;

    // Reference registry and memory
    int                             ref_start [`MB_MODEL_COUNT];
    int                             ref_size  [`MB_MODEL_COUNT];
    model_buffer_pkg::model_state_e ref_state [`MB_MODEL_COUNT];
    model_buffer_pkg::triangle_t    ref_mem   [`MB_TRIANGLE_COUNT];
    int                             ref_next_free;
    int                             ref_prev_model;
    logic                           ref_prev_seen;

    expect_t                      expect_q [$];
    logic                         stall_mode;     // Random out_ready gaps on
    logic [15:0]                  lfsr_q;
    int                           cycle_count;
    logic                         held_valid;     // Result was stalled last cycle
    model_buffer_pkg::triangle_t  held_triangle;
    logic                         held_last;
    model_buffer_pkg::model_idx_t held_model;
    model_buffer_pkg::tri_idx_t   held_index;
    logic                         valid_known;    // A prediction for out_valid exists
    logic                         valid_expected;

    model_buffer_top UUT (
        .clk            (clk),
        .rstn           (rstn),
        .write_valid    (write_valid),
        .write_model    (write_model),
        .write_triangle (write_triangle),
        .read_valid     (read_valid),
        .read_ready     (read_ready),
        .read_model     (read_model),
        .read_index     (read_index),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_triangle   (out_triangle),
        .out_last       (out_last),
        .out_model      (out_model),
        .out_index      (out_index)
    );

    always #2 clk = ~clk;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v      = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
        return v;
    endfunction

    function automatic model_buffer_pkg::vertex_t random_vertex();
        model_buffer_pkg::vertex_t v;
        logic [31:0]               r;
        r   = take_bits(`MB_COORD_WIDTH);
        v.x = r[`MB_COORD_WIDTH-1:0];
        r   = take_bits(`MB_COORD_WIDTH);
        v.y = r[`MB_COORD_WIDTH-1:0];
        r   = take_bits(`MB_COORD_WIDTH);
        v.z = r[`MB_COORD_WIDTH-1:0];
        return v;
    endfunction

    function automatic model_buffer_pkg::triangle_t random_triangle();
        model_buffer_pkg::triangle_t t;
        for (int k = 0; k < 3; k++) begin
            t[k] = random_vertex();
        end
        return t;
    endfunction

    // Registry rules: seal on model change, drop on sealed or full
    task automatic apply_reference_write(input model_buffer_pkg::model_idx_t m,
                                         input model_buffer_pkg::triangle_t t);
        int addr;
        if (ref_state[m] != model_buffer_pkg::MODEL_WRITTEN &&
            ref_next_free < `MB_TRIANGLE_COUNT) begin
            if (ref_prev_seen && int'(m) != ref_prev_model &&
                ref_state[ref_prev_model] == model_buffer_pkg::MODEL_WRITING) begin
                ref_state[ref_prev_model] = model_buffer_pkg::MODEL_WRITTEN;
            end
            if (ref_state[m] == model_buffer_pkg::MODEL_EMPTY) begin
                ref_start[m] = ref_next_free;
                ref_state[m] = model_buffer_pkg::MODEL_WRITING;
            end
            addr = (ref_start[m] + ref_size[m]) % `MB_TRIANGLE_COUNT;
            ref_mem[model_buffer_pkg::tri_idx_t'(addr)] = t;
            ref_size[m]    = ref_size[m] + 1;
            ref_next_free  = ref_next_free + 1;
            ref_prev_model = int'(m);
            ref_prev_seen  = 1'b1;
        end
    endtask

    function automatic expect_t expected_result(input model_buffer_pkg::model_idx_t m,
                                                input model_buffer_pkg::tri_idx_t idx);
        expect_t e;
        int      addr;
        addr       = (ref_start[m] + int'(idx)) % `MB_TRIANGLE_COUNT;
        e.hit      = int'(idx) < ref_size[m];
        e.last     = (int'(idx) + 1) == ref_size[m];
        e.model    = m;
        e.index    = idx;
        e.triangle = ref_mem[model_buffer_pkg::tri_idx_t'(addr)];
        return e;
    endfunction

    task automatic check_value(input string name, input logic [CHECK_WIDTH-1:0] got,
                               input logic [CHECK_WIDTH-1:0] expected);
        if (got !== expected) begin
            $display("MISMATCH %s got=%0h expected=%0h", name, got, expected);
            $display(">>> FAIL");
            $fatal(1, "Stopped at first error");
        end
    endtask

    task automatic stop_with_error(input string msg);
        $display("ERROR: %s", msg);
        $display(">>> FAIL");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic draw_out_ready();
        if (stall_mode) begin
            out_ready = take_bits(2) != 32'd3;   // Low about one cycle in four
        end else begin
            out_ready = 1'b1;
        end
    endtask

    task automatic issue_write(input model_buffer_pkg::model_idx_t m,
                               input model_buffer_pkg::triangle_t t);
        @(negedge clk);
        read_valid     = 1'b0;
        write_valid    = 1'b1;
        write_model    = m;
        write_triangle = t;
        apply_reference_write(m, t);
    endtask

    // Holds the request until read_ready was high before a rising edge
    task automatic issue_read(input model_buffer_pkg::model_idx_t m,
                              input model_buffer_pkg::tri_idx_t idx);
        @(negedge clk);
        write_valid = 1'b0;
        read_valid  = 1'b1;
        read_model  = m;
        read_index  = idx;
        draw_out_ready();
        #1;
        while (!read_ready) begin
            @(negedge clk);
            draw_out_ready();
            #1;
        end
    endtask

    task automatic read_whole_model(input model_buffer_pkg::model_idx_t m);
        for (int i = 0; i < ref_size[m]; i++) begin
            issue_read(m, model_buffer_pkg::tri_idx_t'(i));
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            write_valid = 1'b0;
            read_valid  = 1'b0;
            draw_out_ready();
        end
    endtask

    // Comparison process, sampled mid low phase
    always @(negedge clk) begin
        expect_t e;
        #1;
        if (rstn) begin
            if (valid_known) begin
                check_value("out_valid", CHECK_WIDTH'(out_valid), CHECK_WIDTH'(valid_expected));
            end
            // Request side is open whenever the output register is free or drains
            check_value("read_ready", CHECK_WIDTH'(read_ready),
                        CHECK_WIDTH'(!out_valid || out_ready));
            if (held_valid) begin
                check_value("out_triangle", CHECK_WIDTH'(out_triangle),
                            CHECK_WIDTH'(held_triangle));
                check_value("out_last", CHECK_WIDTH'(out_last), CHECK_WIDTH'(held_last));
                check_value("out_model", CHECK_WIDTH'(out_model), CHECK_WIDTH'(held_model));
                check_value("out_index", CHECK_WIDTH'(out_index), CHECK_WIDTH'(held_index));
            end
            if (out_valid && out_ready) begin
                if (expect_q.size() == 0) begin
                    stop_with_error("a result came out while no hit was expected");
                end else begin
                    e = expect_q.pop_front();
                    check_value("out_triangle", CHECK_WIDTH'(out_triangle),
                                CHECK_WIDTH'(e.triangle));
                    check_value("out_last", CHECK_WIDTH'(out_last), CHECK_WIDTH'(e.last));
                    check_value("out_model", CHECK_WIDTH'(out_model), CHECK_WIDTH'(e.model));
                    check_value("out_index", CHECK_WIDTH'(out_index), CHECK_WIDTH'(e.index));
                end
            end
            held_valid    = out_valid && !out_ready;
            held_triangle = out_triangle;
            held_last     = out_last;
            held_model    = out_model;
            held_index    = out_index;
            valid_expected = out_valid && !out_ready;   // Stalled result stays, drained one goes
            if (read_valid && read_ready) begin
                e = expected_result(read_model, read_index);
                valid_expected = e.hit;   // Result one cycle after the request
                if (e.hit) begin
                    expect_q.push_back(e);   // Misses leave nothing to compare
                end
            end
            valid_known = 1'b1;
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("ERROR: timeout after %0d cycles, the DUT stopped responding",
                     cycle_count);
            $display(">>> FAIL");
            $fatal(1, "Run ended by the cycle limit");
        end
    end

    initial begin
        int len;
        int left;
        clk            = 1'b0;
        rstn           = 1'b0;
        write_valid    = 1'b0;
        write_model    = '0;
        write_triangle = '0;
        read_valid     = 1'b0;
        read_model     = '0;
        read_index     = '0;
        out_ready      = 1'b1;
        stall_mode     = 1'b0;
        held_valid     = 1'b0;
        valid_known    = 1'b0;
        valid_expected = 1'b0;
        lfsr_q         = 16'd93;
        cycle_count    = 0;
        for (int m = 0; m < `MB_MODEL_COUNT; m++) begin
            ref_start[m] = 0;
            ref_size[m]  = 0;
            ref_state[m] = model_buffer_pkg::MODEL_EMPTY;
        end
        ref_next_free  = 0;
        ref_prev_model = 0;
        ref_prev_seen  = 1'b0;
        repeat (3) @(negedge clk);
        rstn = 1'b1;

        // Empty store returns nothing
        @(negedge clk);
        #1;
        check_value("out_valid", CHECK_WIDTH'(out_valid), CHECK_WIDTH'(1'b0));
        check_value("out_last", CHECK_WIDTH'(out_last), CHECK_WIDTH'(1'b0));
        for (int m = 0; m < `MB_MODEL_COUNT; m++) begin
            issue_read(model_buffer_pkg::model_idx_t'(m), '0);
        end
        idle_cycles(2);

        for (int m = 0; m < MODELS_USED; m++) begin
            len = int'(take_bits(5)) + 1;
            for (int i = 0; i < len; i++) begin
                issue_write(model_buffer_pkg::model_idx_t'(m), random_triangle());
            end
        end
        idle_cycles(1);
        for (int m = 0; m < MODELS_USED; m++) begin
            read_whole_model(model_buffer_pkg::model_idx_t'(m));
        end

        // Misses mixed with a hit that must still arrive
        for (int m = 0; m < MODELS_USED; m++) begin
            len = ref_size[m] + int'(take_bits(3));
            issue_read(model_buffer_pkg::model_idx_t'(m),
                       model_buffer_pkg::tri_idx_t'(ref_size[m]));
            issue_read(model_buffer_pkg::model_idx_t'(m), model_buffer_pkg::tri_idx_t'(len));
            issue_read(model_buffer_pkg::model_idx_t'(m), '0);
        end

        // Model 1 is sealed, these writes vanish
        for (int i = 0; i < REVISIT_WRITES; i++) begin
            issue_write(model_buffer_pkg::model_idx_t'(1), random_triangle());
        end
        read_whole_model(model_buffer_pkg::model_idx_t'(1));
        issue_read(model_buffer_pkg::model_idx_t'(1), model_buffer_pkg::tri_idx_t'(ref_size[1]));

        stall_mode = 1'b1;
        for (int m = 0; m < MODELS_USED; m++) begin
            read_whole_model(model_buffer_pkg::model_idx_t'(m));
        end
        stall_mode = 1'b0;
        idle_cycles(4);

        // Overfill, model 6 finds the memory full
        left = `MB_TRIANGLE_COUNT - ref_next_free;
        for (int i = 0; i < left + FILL_EXTRA; i++) begin
            issue_write(model_buffer_pkg::model_idx_t'(5), random_triangle());
        end
        for (int i = 0; i < 2; i++) begin
            issue_write(model_buffer_pkg::model_idx_t'(6), random_triangle());
        end
        read_whole_model(model_buffer_pkg::model_idx_t'(5));
        issue_read(model_buffer_pkg::model_idx_t'(5), model_buffer_pkg::tri_idx_t'(ref_size[5]));
        issue_read(model_buffer_pkg::model_idx_t'(6), '0);

        idle_cycles(8);
        if (expect_q.size() != 0) begin
            $display("ERROR: %0d expected results never came out", expect_q.size());
            $display(">>> FAIL");
            $fatal(1, "Results missing at the end of the run");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+logic
logic/model_buffer_pkg.sv
logic/model_buffer_ifs.sv
logic/vertex_bank.sv
logic/model_registry.sv
logic/triangle_output.sv
logic/model_buffer_top.sv
tb/tb_model_buffer.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the model buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps \
    --top-module tb_model_buffer -f compile.f -o sim_model_buffer
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_model_buffer 2>&1)
status=$?
printf '%s\n' "$output"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q '^>>> PASS$'; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1
